//--- src/rv32i_types.sv
package rv32i_types;

    // instruction word
    localparam int INST_W = 32;                       // rv32i fixed width

    // queue geometry
    localparam int QUEUE_DEPTH = 8;                   // entries per class queue, power of two
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH); // index bits without wrap bit

    // program order tag
    // two more bits than the index so 16 in flight stays under half the tag range
    localparam int SEQ_W = QUEUE_PTR_W + 2;

    // opcode field, inst[6:0]
    localparam int OPCODE_W = 7;

    typedef logic [INST_W-1:0]            inst_t;     // one instruction word
    typedef logic [SEQ_W-1:0]             seq_t;      // wrapping age tag
    typedef logic [SEQ_W+INST_W-1:0]      entry_t;    // {tag, inst} as stored in a queue
    typedef logic [QUEUE_PTR_W:0]         ptr_t;      // index plus wrap bit
    typedef logic [OPCODE_W-1:0]          opcode_t;   // major opcode
    typedef logic [0:0]                   op_class_t; // 1 = memory, 0 = alu

    // memory class opcodes
    localparam opcode_t OP_LOAD  = 7'b0000011;        // lb/lh/lw/lbu/lhu
    localparam opcode_t OP_STORE = 7'b0100011;        // sb/sh/sw

    // class encodings on issue_class
    localparam op_class_t CLASS_ALU = 1'b0;
    localparam op_class_t CLASS_MEM = 1'b1;

    // field positions inside entry_t
    localparam int ENTRY_INST_LSB = 0;                // instruction in the low bits
    localparam int ENTRY_SEQ_LSB  = INST_W;           // tag sits right above it

    // opcode position inside an instruction
    localparam int OPCODE_LSB = 0;

endpackage : rv32i_types

//--- src/queue.sv
`timescale 1ns/1ps

module queue
    import rv32i_types::*;
(
    input  logic   clk,
    input  logic   rst,

    input  entry_t wdata,      // word written at the tail
    input  logic   enqueue,    // push request that is dropped when full

    output entry_t rdata,      // word at the head with no read latency
    input  logic   dequeue,    // pop request that is dropped when empty

    output logic   full,
    output logic   empty
);

    entry_t storage [QUEUE_DEPTH];            // circular buffer of tagged words

    ptr_t head;                               // next entry to read with the wrap bit as msb
    ptr_t tail;                               // next free slot with the wrap bit as msb

    logic [QUEUE_PTR_W-1:0] head_idx;         // head without wrap bit
    logic [QUEUE_PTR_W-1:0] tail_idx;         // tail without wrap bit
    logic                   idx_match;        // both pointers on the same slot

    logic do_enq;                             // enqueue that actually happens
    logic do_deq;                             // dequeue that actually happens

    assign head_idx  = head[QUEUE_PTR_W-1:0];
    assign tail_idx  = tail[QUEUE_PTR_W-1:0];
    assign idx_match = (head_idx == tail_idx);

    // on the same slot the wrap bits tell full from empty
    assign full  = idx_match && (head[QUEUE_PTR_W] != tail[QUEUE_PTR_W]);
    assign empty = idx_match && (head[QUEUE_PTR_W] == tail[QUEUE_PTR_W]);

    // full and empty both come from the pointers of this cycle,
    // so push and pop together are fine whenever each is legal alone
    assign do_enq = enqueue && !full;
    assign do_deq = dequeue && !empty;

    // head entry is always visible
    assign rdata = storage[head_idx];         // only meaningful when !empty

    // payload write
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            storage[tail_idx] <= wdata;       // slot at tail is free
        end
    end

    // pointer update
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head <= '0;                       // empty after reset
            tail <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                tail <= tail + ptr_t'(1);     // carry into msb flips the wrap bit
            end
            if (do_deq)
            begin
                head <= head + ptr_t'(1);     // depth is a power of two so this wraps cleanly
            end
        end
    end

endmodule : queue

//--- src/dispatch_router.sv
`timescale 1ns/1ps

module dispatch_router
    import rv32i_types::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   disp_valid,      // decode has an instruction
    input  inst_t  disp_inst,       // decoded instruction word
    output logic   disp_ready,      // target class queue has room

    input  logic   alu_full,        // alu queue flag
    input  logic   mem_full,        // memory queue flag

    output logic   alu_enqueue,     // push into alu queue
    output logic   mem_enqueue,     // push into memory queue
    output entry_t enq_entry        // {seq, inst} shared by both queues
);

    opcode_t   opcode;              // major opcode of the incoming word
    op_class_t inst_class;          // which queue it belongs to
    logic      accept;              // dispatch handshake completes this cycle
    seq_t      seq;                 // tag for the next accepted instruction

    assign opcode = disp_inst[OPCODE_LSB +: OPCODE_W];

    // loads and stores go to the memory queue, everything else to alu
    assign inst_class = ((opcode == OP_LOAD) || (opcode == OP_STORE)) ? CLASS_MEM : CLASS_ALU;

    // ready looks only at the queue this instruction would land in
    assign disp_ready = (inst_class == CLASS_MEM) ? !mem_full : !alu_full;
    assign accept     = disp_valid && disp_ready;

    assign alu_enqueue = accept && (inst_class == CLASS_ALU);
    assign mem_enqueue = accept && (inst_class == CLASS_MEM);

    // both queues see the same word, only one enqueue is high
    assign enq_entry = {seq, disp_inst};

    // program order counter, wraps freely
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            seq <= '0;
        end
        else if (accept)
        begin
            seq <= seq + seq_t'(1);  // one tag per accepted instruction
        end
    end

endmodule : dispatch_router

//--- src/issue_select.sv
`timescale 1ns/1ps

module issue_select
    import rv32i_types::*;
(
    input  entry_t    alu_head,     // alu queue head word
    input  logic      alu_empty,
    input  entry_t    mem_head,     // memory queue head word
    input  logic      mem_empty,

    input  logic      issue_ready,  // execute takes the instruction
    output logic      issue_valid,
    output inst_t     issue_inst,
    output op_class_t issue_class,

    output logic      alu_dequeue,  // pop alu head on transfer
    output logic      mem_dequeue   // pop memory head on transfer
);

    seq_t  alu_seq;                 // tag of alu head
    seq_t  mem_seq;                 // tag of memory head
    seq_t  seq_diff;                // alu minus mem, modulo tag range
    logic  alu_older;               // alu head was dispatched first
    logic  pick_mem;                // memory head is the one presented
    logic  issue_fire;              // issue handshake completes

    assign alu_seq = alu_head[ENTRY_SEQ_LSB +: SEQ_W];
    assign mem_seq = mem_head[ENTRY_SEQ_LSB +: SEQ_W];

    // in-flight span is below half the range, so a negative wrapped
    // difference means the alu tag comes first in program order
    assign seq_diff  = alu_seq - mem_seq;
    assign alu_older = seq_diff[SEQ_W-1];

    // tags are unique, so with both heads present exactly one is older
    always_comb
    begin
        if (mem_empty)
        begin
            pick_mem = 1'b0;        // alu head or nothing
        end
        else if (alu_empty)
        begin
            pick_mem = 1'b1;        // only memory has work
        end
        else
        begin
            pick_mem = !alu_older;  // oldest head wins
        end
    end

    assign issue_valid = !alu_empty || !mem_empty;
    assign issue_inst  = pick_mem ? mem_head[ENTRY_INST_LSB +: INST_W]
                                  : alu_head[ENTRY_INST_LSB +: INST_W];
    assign issue_class = pick_mem ? CLASS_MEM : CLASS_ALU;

    // handshake turns straight into a pop of the chosen queue
    assign issue_fire  = issue_valid && issue_ready;
    assign alu_dequeue = issue_fire && !pick_mem;
    assign mem_dequeue = issue_fire && pick_mem;

endmodule : issue_select

//--- src/issue_buffer.sv
`timescale 1ns/1ps

module issue_buffer
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // dispatch side, valid/ready
    input  logic      disp_valid,
    input  inst_t     disp_inst,
    output logic      disp_ready,

    // issue side, valid/ready
    output logic      issue_valid,
    output inst_t     issue_inst,
    output op_class_t issue_class,
    input  logic      issue_ready
);

    entry_t enq_entry;              // tagged word from the router
    logic   alu_enqueue;
    logic   mem_enqueue;

    entry_t alu_head;               // heads seen by the selector
    entry_t mem_head;
    logic   alu_empty;
    logic   alu_full;
    logic   mem_empty;
    logic   mem_full;
    logic   alu_dequeue;            // pops driven by the selector
    logic   mem_dequeue;

    dispatch_router dispatch_router_inst (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_inst   (disp_inst),
        .disp_ready  (disp_ready),
        .alu_full    (alu_full),
        .mem_full    (mem_full),
        .alu_enqueue (alu_enqueue),
        .mem_enqueue (mem_enqueue),
        .enq_entry   (enq_entry)
    );

    // alu class storage
    queue alu_queue_inst (
        .clk     (clk),
        .rst     (rst),
        .wdata   (enq_entry),
        .enqueue (alu_enqueue),
        .rdata   (alu_head),
        .dequeue (alu_dequeue),
        .full    (alu_full),
        .empty   (alu_empty)
    );

    // load/store class storage
    queue mem_queue_inst (
        .clk     (clk),
        .rst     (rst),
        .wdata   (enq_entry),
        .enqueue (mem_enqueue),
        .rdata   (mem_head),
        .dequeue (mem_dequeue),
        .full    (mem_full),
        .empty   (mem_empty)
    );

    issue_select issue_select_inst (
        .alu_head    (alu_head),
        .alu_empty   (alu_empty),
        .mem_head    (mem_head),
        .mem_empty   (mem_empty),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .issue_class (issue_class),
        .alu_dequeue (alu_dequeue),
        .mem_dequeue (mem_dequeue)
    );

endmodule : issue_buffer

//--- testbench/issue_buffer_asserts.sv
`timescale 1ns/1ps

module issue_buffer_asserts
    import rv32i_types::*;
(
    input logic  clk,
    input logic  rst,
    input logic  disp_valid,
    input logic  disp_ready,
    input logic  alu_full,
    input logic  alu_empty,
    input logic  mem_full,
    input logic  mem_empty,
    input logic  alu_dequeue,
    input logic  mem_dequeue,
    input logic  issue_valid,
    input logic  issue_ready,
    input inst_t issue_inst
);

    // one move per cycle on a depth of 8 never jumps between empty and full
    full_empty_excl: assert property (@(posedge clk) disable iff (rst)
        !(alu_full && $past(alu_empty)) && !(alu_empty && $past(alu_full)) &&
        !(mem_full && $past(mem_empty)) && !(mem_empty && $past(mem_full)))
        else $error("queue flagged full and empty together");

    // nothing arriving into two empty queues leaves the issue port idle
    idle_when_empty: assert property (@(posedge clk) disable iff (rst)
        (alu_empty && mem_empty && !(disp_valid && disp_ready)) |=> !issue_valid)
        else $error("issue_valid with both queues empty");

    alu_pop_legal: assert property (@(posedge clk) disable iff (rst)
        alu_dequeue |-> !alu_empty)
        else $error("dequeue on empty alu queue");

    mem_pop_legal: assert property (@(posedge clk) disable iff (rst)
        mem_dequeue |-> !mem_empty)
        else $error("dequeue on empty memory queue");

    // new arrivals are younger so a stalled head keeps its place
    issue_hold: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && !issue_ready) |=> $stable(issue_inst))
        else $error("issue_inst changed while stalled");

endmodule : issue_buffer_asserts

bind issue_buffer issue_buffer_asserts issue_buffer_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .disp_valid  (disp_valid),
    .disp_ready  (disp_ready),
    .alu_full    (alu_full),
    .alu_empty   (alu_empty),
    .mem_full    (mem_full),
    .mem_empty   (mem_empty),
    .alu_dequeue (alu_dequeue),
    .mem_dequeue (mem_dequeue),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_inst  (issue_inst)
);

//--- testbench/issue_buffer_tb.sv
`timescale 1ns/1ps

module issue_buffer_tb
    import rv32i_types::*;
();

    localparam int          CLK_HALF       = 4;                  // 8 ns period
    localparam int          RESET_CYCLES   = 8;
    localparam int          NUM_INST       = 400;                // instructions to dispatch
    localparam int          TIMEOUT_CYCLES = NUM_INST * 8 + 500; // generous bound on the whole run
    localparam int          PHASE_CYCLES   = 48;                 // one stall or drain phase
    localparam logic [31:0] LFSR_SEED      = 32'hc19d_a2ad;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;      // x^32 + x^22 + x^2 + x + 1

    logic      clk;
    logic      rst;
    logic      disp_valid;
    inst_t     disp_inst;
    logic      disp_ready;
    logic      issue_valid;
    inst_t     issue_inst;
    op_class_t issue_class;
    logic      issue_ready;

    logic [31:0] lfsr_state   = LFSR_SEED;
    int          cycle_count  = 0;
    logic        disp_stalled = 1'b0;        // offered last cycle and not taken so it is held
    inst_t       model_q [$];                // accepted and not yet issued with the oldest first
    int          class_count [2] = '{0, 0};  // model occupancy indexed by op_class_t
    int          accepted = 0;
    int          issued   = 0;               // issue handshakes seen at the clock edge

    issue_buffer issue_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_inst   (disp_inst),
        .disp_ready  (disp_ready),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .issue_class (issue_class),
        .issue_ready (issue_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;       // drives the phases and the watchdog
    end

    // transfers counted straight off the dut ports
    always @(posedge clk)
    begin
        if (issue_valid && issue_ready)
        begin
            issued <= issued + 1;
        end
    end

    // watchdog
    initial
    begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, %0d accepted, %0d issued", cycle_count, accepted,
                 issued);
        $display("Simulation finished: FAIL");
        $fatal(1, "run did not complete in time");
    end

    // galois form shifts right and folds the taps in on a one
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit with the lsb drawn first
    task automatic draw_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++)
        begin
            bits[i]    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // loads and stores are the memory class
    function automatic op_class_t class_of(input inst_t inst);
        opcode_t op;
        op = inst[6:0];
        return ((op == OP_LOAD) || (op == OP_STORE)) ? 1'b1 : 1'b0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_class(input string name, input op_class_t got, input op_class_t exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // runs from 1 ns after an edge to 1 ns after the next one
    task automatic step_cycle();
        logic [31:0] bits;
        inst_t       next_inst;
        logic        stall_phase;
        logic        disp_fire;
        logic        issue_fire;
        if (!disp_stalled)
        begin
            if (accepted < NUM_INST)
            begin
                draw_bits(1, bits);
                disp_valid = bits[0];         // about half the cycles carry an instruction
                draw_bits(32, bits);
                next_inst = bits;
                draw_bits(2, bits);
                if (bits[1:0] == 2'd0)
                begin
                    next_inst[6:0] = OP_LOAD;
                end
                else if (bits[1:0] == 2'd1)
                begin
                    next_inst[6:0] = OP_STORE;
                end
                disp_inst = next_inst;        // otherwise the random opcode stays
            end
            else
            begin
                disp_valid = 1'b0;            // all sent so just drain
            end
        end
        stall_phase = (accepted < NUM_INST) && (((cycle_count / PHASE_CYCLES) % 2) == 0);
        draw_bits(3, bits);
        issue_ready = stall_phase ? (bits[2:0] == 3'd0) : (bits[2:0] != 3'd0);
        #2;                                   // outputs have settled well before the edge
        if (disp_valid)
        begin
            check_flag("disp_ready", disp_ready, class_count[class_of(disp_inst)] < QUEUE_DEPTH);
        end
        check_flag("issue_valid", issue_valid, model_q.size() != 0);
        if (issue_valid)
        begin
            check_inst("issue_inst", issue_inst, model_q[0]);   // oldest unissued
            check_class("issue_class", issue_class, class_of(model_q[0]));
        end
        disp_fire  = disp_valid && disp_ready;
        issue_fire = issue_valid && issue_ready;
        if (issue_fire)
        begin
            class_count[class_of(model_q[0])]--;
            void'(model_q.pop_front());
        end
        if (disp_fire)
        begin
            model_q.push_back(disp_inst);
            class_count[class_of(disp_inst)]++;
            accepted++;
        end
        disp_stalled = disp_valid && !disp_ready;
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        logic [31:0] bits;
        int          i;
        rst         = 1'b1;
        disp_valid  = 1'b0;
        disp_inst   = '0;
        issue_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle after reset where ready must not care about the opcode
        for (i = 0; i < 4; i++)
        begin
            draw_bits(32, bits);
            disp_inst = bits;
            if (i == 1)
            begin
                disp_inst[6:0] = OP_LOAD;     // memory class word
            end
            else if (i == 2)
            begin
                disp_inst[6:0] = OP_STORE;
            end
            #2;
            check_flag("disp_ready", disp_ready, 1'b1);
            check_flag("issue_valid", issue_valid, 1'b0);
            @(posedge clk);
            #1;
        end
        while (accepted < NUM_INST)
        begin
            step_cycle();
        end
        while (model_q.size() != 0)
        begin
            step_cycle();
        end
        #2;
        check_flag("issue_valid", issue_valid, 1'b0);
        if (issued != NUM_INST)
        begin
            abort_run($sformatf("issue handshake count wrong: %0d issued out of %0d",
                                issued, NUM_INST));
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule : issue_buffer_tb

//--- issue_buffer.f
src/rv32i_types.sv
src/queue.sv
src/dispatch_router.sv
src/issue_select.sv
src/issue_buffer.sv
testbench/issue_buffer_asserts.sv
testbench/issue_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module issue_buffer_tb \
    -f issue_buffer.f \
    -Mdir obj_dir \
    -o issue_buffer_sim

./obj_dir/issue_buffer_sim
